// ==== design/dma_ctrl_pkg.sv ====
// DMA control front end shared definitions
// Widths, queue depth, register map and opcode encoding

package dma_ctrl_pkg;

   // Transfer ids
   localparam int NB_TRANSFERS = 4;
   localparam int SID_WIDTH    = 2;

   // Field widths
   localparam int LEN_WIDTH      = 16;
   localparam int TCDM_ADD_WIDTH = 12;
   localparam int EXT_ADD_WIDTH  = 29;
   localparam int PE_ID_WIDTH    = 1;

   // Command queues
   localparam int QUEUE_DEPTH = 2;
   // Entry holds sid, increment flag, opcode and length
   localparam int CMD_WIDTH   = SID_WIDTH + 2 + LEN_WIDTH;

   // Bit positions in a REG_CMD write word
   localparam int CMD_OPC_BIT = 17;
   localparam int CMD_INC_BIT = 18;

   // Register offsets, taken from address bits 4 to 2
   typedef enum logic [2:0] {
      REG_CMD      = 3'd0,
      REG_TCDM_ADD = 3'd1,
      REG_EXT_ADD  = 3'd2,
      REG_STATUS   = 3'd3
   } ctrl_reg_e;

   typedef enum logic {
      OPC_LOAD  = 1'b0,   // external to TCDM
      OPC_STORE = 1'b1    // TCDM to external
   } dma_opc_e;

endpackage

// ==== design/cmd_fifo.sv ====
// Small synchronous FIFO for the DMA command queues
// Circular buffer with occupancy counter, oldest entry shown at data_o

module cmd_fifo #(
   parameter int DATA_WIDTH = 8,
   parameter int DEPTH      = 2
) (
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  push_i,
   input  logic [DATA_WIDTH-1:0] data_i,
   output logic                  full_o,
   input  logic                  pop_i,
   output logic [DATA_WIDTH-1:0] data_o,
   output logic                  valid_o
);

   localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_WIDTH = $clog2(DEPTH + 1);

   logic [DATA_WIDTH-1:0] mem_q [DEPTH];
   logic [PTR_WIDTH-1:0]  wr_ptr_q;
   logic [PTR_WIDTH-1:0]  rd_ptr_q;
   logic [CNT_WIDTH-1:0]  count_q;
   logic                  do_push;
   logic                  do_pop;

   // Pointer step with wrap at DEPTH
   function automatic logic [PTR_WIDTH-1:0] ptr_inc(logic [PTR_WIDTH-1:0] ptr);
      if (ptr == PTR_WIDTH'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign full_o  = (count_q == CNT_WIDTH'(DEPTH));
   assign valid_o = (count_q != '0);
   assign data_o  = mem_q[rd_ptr_q];

   // Push into a full queue or pop from an empty one is dropped
   assign do_push = push_i && !full_o;
   assign do_pop  = pop_i && valid_o;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= ptr_inc(wr_ptr_q);
         end
         if (do_pop) begin
            rd_ptr_q <= ptr_inc(rd_ptr_q);
         end
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // Storage
   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem_q[wr_ptr_q] <= data_i;
      end
   end

endmodule

// ==== design/ctrl_fsm.sv ====
// Control target decoder of the DMA front end
// Turns register accesses into queue pushes, sid requests and clears,
// and returns a registered response one cycle after every grant

module ctrl_fsm (
   input  logic                                   clk_i,
   input  logic                                   reset_i,
   // Control target
   input  logic                                   ctrl_targ_req_i,
   input  logic                                   ctrl_targ_type_i,
   input  logic [31:0]                            ctrl_targ_add_i,
   input  logic [31:0]                            ctrl_targ_data_i,
   input  logic [dma_ctrl_pkg::PE_ID_WIDTH-1:0]   ctrl_targ_id_i,
   output logic                                   ctrl_targ_gnt_o,
   output logic                                   ctrl_targ_r_valid_o,
   output logic [31:0]                            ctrl_targ_r_data_o,
   output logic                                   ctrl_targ_r_opc_o,
   output logic [dma_ctrl_pkg::PE_ID_WIDTH-1:0]   ctrl_targ_r_id_o,
   // Transfer allocator
   output logic                                   trans_alloc_req_o,
   input  logic                                   trans_alloc_gnt_i,
   input  logic [dma_ctrl_pkg::SID_WIDTH-1:0]     trans_alloc_ret_i,
   output logic [dma_ctrl_pkg::NB_TRANSFERS-1:0]  trans_alloc_clr_o,
   input  logic [dma_ctrl_pkg::NB_TRANSFERS-1:0]  trans_alloc_status_i,
   // Queue push side
   input  logic                                   cmd_full_i,
   output logic                                   cmd_push_o,
   output logic [dma_ctrl_pkg::CMD_WIDTH-1:0]     cmd_data_o,
   input  logic                                   tcdm_full_i,
   output logic                                   tcdm_push_o,
   output logic [dma_ctrl_pkg::TCDM_ADD_WIDTH-1:0] tcdm_data_o,
   input  logic                                   ext_full_i,
   output logic                                   ext_push_o,
   output logic [dma_ctrl_pkg::EXT_ADD_WIDTH-1:0] ext_data_o
);

   dma_ctrl_pkg::ctrl_reg_e            reg_sel;
   dma_ctrl_pkg::dma_opc_e             cmd_opc;
   logic                               wr_acc;
   logic                               rd_acc;
   logic [dma_ctrl_pkg::SID_WIDTH-1:0] cur_sid_q;
   logic [31:0]                        r_data_d;
   logic                               r_opc_d;

   assign reg_sel = dma_ctrl_pkg::ctrl_reg_e'(ctrl_targ_add_i[4:2]);
   assign wr_acc  = ctrl_targ_req_i && ctrl_targ_type_i;
   assign rd_acc  = ctrl_targ_req_i && !ctrl_targ_type_i;

   // Only a command register read reserves a sid
   assign trans_alloc_req_o = rd_acc && (reg_sel == dma_ctrl_pkg::REG_CMD);

   //**********************************************************
   // Address decode and grant
   //**********************************************************

   always_comb begin
      ctrl_targ_gnt_o   = ctrl_targ_req_i;
      cmd_push_o        = 1'b0;
      tcdm_push_o       = 1'b0;
      ext_push_o        = 1'b0;
      trans_alloc_clr_o = '0;
      r_data_d          = '0;
      r_opc_d           = 1'b0;
      case (reg_sel)
         dma_ctrl_pkg::REG_CMD: begin
            if (ctrl_targ_type_i) begin
               ctrl_targ_gnt_o = ctrl_targ_req_i && !cmd_full_i;
               cmd_push_o      = wr_acc && !cmd_full_i;
            end else begin
               // Held off until a sid is free
               ctrl_targ_gnt_o = ctrl_targ_req_i && trans_alloc_gnt_i;
               r_data_d        = 32'(trans_alloc_ret_i);
            end
         end
         dma_ctrl_pkg::REG_TCDM_ADD: begin
            if (ctrl_targ_type_i) begin
               ctrl_targ_gnt_o = ctrl_targ_req_i && !tcdm_full_i;
               tcdm_push_o     = wr_acc && !tcdm_full_i;
            end
         end
         dma_ctrl_pkg::REG_EXT_ADD: begin
            if (ctrl_targ_type_i) begin
               ctrl_targ_gnt_o = ctrl_targ_req_i && !ext_full_i;
               ext_push_o      = wr_acc && !ext_full_i;
            end
         end
         dma_ctrl_pkg::REG_STATUS: begin
            if (wr_acc) begin
               trans_alloc_clr_o = ctrl_targ_data_i[dma_ctrl_pkg::NB_TRANSFERS-1:0];
            end else begin
               r_data_d = 32'(trans_alloc_status_i);
            end
         end
         default: begin
            r_opc_d = 1'b1;
         end
      endcase
   end

   //**********************************************************
   // Queue entries
   //**********************************************************

   assign cmd_opc = ctrl_targ_data_i[dma_ctrl_pkg::CMD_OPC_BIT] ?
                    dma_ctrl_pkg::OPC_STORE : dma_ctrl_pkg::OPC_LOAD;

   assign cmd_data_o  = {cur_sid_q,
                         ctrl_targ_data_i[dma_ctrl_pkg::CMD_INC_BIT],
                         cmd_opc,
                         ctrl_targ_data_i[dma_ctrl_pkg::LEN_WIDTH-1:0]};
   assign tcdm_data_o = ctrl_targ_data_i[dma_ctrl_pkg::TCDM_ADD_WIDTH-1:0];
   assign ext_data_o  = ctrl_targ_data_i[dma_ctrl_pkg::EXT_ADD_WIDTH-1:0];

   //**********************************************************
   // Response and current sid
   //**********************************************************

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ctrl_targ_r_valid_o <= 1'b0;
         cur_sid_q           <= '0;
      end else begin
         ctrl_targ_r_valid_o <= ctrl_targ_gnt_o;
         // Sid of the last reservation goes into the next command
         if (ctrl_targ_gnt_o && trans_alloc_req_o) begin
            cur_sid_q <= trans_alloc_ret_i;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (ctrl_targ_gnt_o) begin
         ctrl_targ_r_data_o <= r_data_d;
         ctrl_targ_r_opc_o  <= r_opc_d;
         ctrl_targ_r_id_o   <= ctrl_targ_id_i;
      end
   end

endmodule

// ==== design/trans_allocator.sv ====
// Transfer id allocator
// Hands out the lowest free sid, tracks done pulses and frees sids
// on a clear mask, reporting allocated and not done as status

module trans_allocator (
   input  logic                                  clk_i,
   input  logic                                  reset_i,
   input  logic                                  trans_alloc_req_i,
   input  logic                                  trans_alloc_take_i,
   input  logic [dma_ctrl_pkg::NB_TRANSFERS-1:0] trans_alloc_clr_i,
   input  logic                                  trans_done_i,
   input  logic [dma_ctrl_pkg::SID_WIDTH-1:0]    trans_done_sid_i,
   output logic                                  trans_alloc_gnt_o,
   output logic [dma_ctrl_pkg::SID_WIDTH-1:0]    trans_alloc_ret_o,
   output logic [dma_ctrl_pkg::NB_TRANSFERS-1:0] trans_alloc_status_o,
   output logic                                  alloc_any_o
);

   logic [dma_ctrl_pkg::NB_TRANSFERS-1:0] alloc_q;
   logic [dma_ctrl_pkg::NB_TRANSFERS-1:0] done_q;
   logic [dma_ctrl_pkg::NB_TRANSFERS-1:0] take_mask;
   logic [dma_ctrl_pkg::NB_TRANSFERS-1:0] done_mask;
   logic                                  free_found;

   // Lowest free sid, scanned from the top so the lowest index wins
   always_comb begin
      free_found        = 1'b0;
      trans_alloc_ret_o = '0;
      for (int i = dma_ctrl_pkg::NB_TRANSFERS - 1; i >= 0; i--) begin
         if (!alloc_q[i]) begin
            free_found        = 1'b1;
            trans_alloc_ret_o = dma_ctrl_pkg::SID_WIDTH'(i);
         end
      end
   end

   assign trans_alloc_gnt_o = trans_alloc_req_i && free_found;

   // Commit only when the bus access itself is granted
   assign take_mask = (trans_alloc_gnt_o && trans_alloc_take_i) ?
                      dma_ctrl_pkg::NB_TRANSFERS'(1) << trans_alloc_ret_o : '0;
   assign done_mask = trans_done_i ?
                      dma_ctrl_pkg::NB_TRANSFERS'(1) << trans_done_sid_i : '0;

   // Clear has priority over a done pulse on the same sid
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         alloc_q <= '0;
         done_q  <= '0;
      end else begin
         alloc_q <= (alloc_q | take_mask) & ~trans_alloc_clr_i;
         done_q  <= (done_q | done_mask) & ~trans_alloc_clr_i;
      end
   end

   assign trans_alloc_status_o = alloc_q & ~done_q;
   assign alloc_any_o          = |alloc_q;

endmodule

// ==== design/ctrl_if.sv ====
// DMA control interface
// Register decoder feeding three command queues, which are joined
// into a single downstream command with a common pop

module ctrl_if (
   input  logic                                   clk_i,
   input  logic                                   reset_i,
   // Control target
   input  logic                                   ctrl_targ_req_i,
   input  logic                                   ctrl_targ_type_i,
   input  logic [31:0]                            ctrl_targ_add_i,
   input  logic [31:0]                            ctrl_targ_data_i,
   input  logic [dma_ctrl_pkg::PE_ID_WIDTH-1:0]   ctrl_targ_id_i,
   output logic                                   ctrl_targ_gnt_o,
   output logic                                   ctrl_targ_r_valid_o,
   output logic [31:0]                            ctrl_targ_r_data_o,
   output logic                                   ctrl_targ_r_opc_o,
   output logic [dma_ctrl_pkg::PE_ID_WIDTH-1:0]   ctrl_targ_r_id_o,
   // Transfer allocator
   output logic                                   trans_alloc_req_o,
   output logic                                   trans_alloc_take_o,
   input  logic                                   trans_alloc_gnt_i,
   input  logic [dma_ctrl_pkg::SID_WIDTH-1:0]     trans_alloc_ret_i,
   output logic [dma_ctrl_pkg::NB_TRANSFERS-1:0]  trans_alloc_clr_o,
   input  logic [dma_ctrl_pkg::NB_TRANSFERS-1:0]  trans_alloc_status_i,
   // Downstream command
   output logic                                   cmd_req_o,
   input  logic                                   cmd_gnt_i,
   output logic [dma_ctrl_pkg::SID_WIDTH-1:0]     cmd_sid_o,
   output logic [dma_ctrl_pkg::LEN_WIDTH-1:0]     cmd_len_o,
   output dma_ctrl_pkg::dma_opc_e                 cmd_opc_o,
   output logic                                   cmd_inc_o,
   output logic [dma_ctrl_pkg::TCDM_ADD_WIDTH-1:0] tcdm_add_o,
   output logic [dma_ctrl_pkg::EXT_ADD_WIDTH-1:0] ext_add_o,
   output logic                                   queue_busy_o
);

   logic                                    cmd_full, cmd_push, cmd_valid;
   logic                                    tcdm_full, tcdm_push, tcdm_valid;
   logic                                    ext_full, ext_push, ext_valid;
   logic [dma_ctrl_pkg::CMD_WIDTH-1:0]      cmd_wdata;
   logic [dma_ctrl_pkg::CMD_WIDTH-1:0]      cmd_entry;
   logic [dma_ctrl_pkg::TCDM_ADD_WIDTH-1:0] tcdm_wdata;
   logic [dma_ctrl_pkg::EXT_ADD_WIDTH-1:0]  ext_wdata;
   logic                                    queue_pop;

   //**********************************************************
   // Address decoder
   //**********************************************************

   ctrl_fsm ctrl_fsm_i (
      .*,
      .cmd_full_i  (cmd_full),
      .cmd_push_o  (cmd_push),
      .cmd_data_o  (cmd_wdata),
      .tcdm_full_i (tcdm_full),
      .tcdm_push_o (tcdm_push),
      .tcdm_data_o (tcdm_wdata),
      .ext_full_i  (ext_full),
      .ext_push_o  (ext_push),
      .ext_data_o  (ext_wdata)
   );

   // The decoder grant commits a sid reservation
   assign trans_alloc_take_o = ctrl_targ_gnt_o;

   //**********************************************************
   // Command, TCDM address and external address queues
   //**********************************************************

   cmd_fifo #(
      .DATA_WIDTH (dma_ctrl_pkg::CMD_WIDTH),
      .DEPTH      (dma_ctrl_pkg::QUEUE_DEPTH)
   ) cmd_fifo_i (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .push_i  (cmd_push),
      .data_i  (cmd_wdata),
      .full_o  (cmd_full),
      .pop_i   (queue_pop),
      .data_o  (cmd_entry),
      .valid_o (cmd_valid)
   );

   cmd_fifo #(
      .DATA_WIDTH (dma_ctrl_pkg::TCDM_ADD_WIDTH),
      .DEPTH      (dma_ctrl_pkg::QUEUE_DEPTH)
   ) tcdm_fifo_i (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .push_i  (tcdm_push),
      .data_i  (tcdm_wdata),
      .full_o  (tcdm_full),
      .pop_i   (queue_pop),
      .data_o  (tcdm_add_o),
      .valid_o (tcdm_valid)
   );

   cmd_fifo #(
      .DATA_WIDTH (dma_ctrl_pkg::EXT_ADD_WIDTH),
      .DEPTH      (dma_ctrl_pkg::QUEUE_DEPTH)
   ) ext_fifo_i (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .push_i  (ext_push),
      .data_i  (ext_wdata),
      .full_o  (ext_full),
      .pop_i   (queue_pop),
      .data_o  (ext_add_o),
      .valid_o (ext_valid)
   );

   // Command offered only once all three parts are queued
   assign cmd_req_o    = cmd_valid && tcdm_valid && ext_valid;
   assign queue_pop    = cmd_gnt_i && cmd_req_o;
   assign queue_busy_o = cmd_valid || tcdm_valid || ext_valid;

   // Entry layout is {sid, inc, opc, len}
   assign cmd_len_o = cmd_entry[dma_ctrl_pkg::LEN_WIDTH-1:0];
   assign cmd_opc_o = dma_ctrl_pkg::dma_opc_e'(cmd_entry[dma_ctrl_pkg::LEN_WIDTH]);
   assign cmd_inc_o = cmd_entry[dma_ctrl_pkg::LEN_WIDTH+1];
   assign cmd_sid_o = cmd_entry[dma_ctrl_pkg::CMD_WIDTH-1 -: dma_ctrl_pkg::SID_WIDTH];

endmodule

// ==== design/dma_ctrl_top.sv ====
// DMA command front end top level
// Control interface plus transfer id allocator, with a busy flag

module dma_ctrl_top (
   input  logic                                   clk_i,
   input  logic                                   reset_i,
   // Control target
   input  logic                                   ctrl_targ_req_i,
   input  logic                                   ctrl_targ_type_i,
   input  logic [31:0]                            ctrl_targ_add_i,
   input  logic [31:0]                            ctrl_targ_data_i,
   input  logic [dma_ctrl_pkg::PE_ID_WIDTH-1:0]   ctrl_targ_id_i,
   output logic                                   ctrl_targ_gnt_o,
   output logic                                   ctrl_targ_r_valid_o,
   output logic [31:0]                            ctrl_targ_r_data_o,
   output logic                                   ctrl_targ_r_opc_o,
   output logic [dma_ctrl_pkg::PE_ID_WIDTH-1:0]   ctrl_targ_r_id_o,
   // Completion from the backend
   input  logic                                   trans_done_i,
   input  logic [dma_ctrl_pkg::SID_WIDTH-1:0]     trans_done_sid_i,
   // Downstream command
   output logic                                   cmd_req_o,
   input  logic                                   cmd_gnt_i,
   output logic [dma_ctrl_pkg::SID_WIDTH-1:0]     cmd_sid_o,
   output logic [dma_ctrl_pkg::LEN_WIDTH-1:0]     cmd_len_o,
   output dma_ctrl_pkg::dma_opc_e                 cmd_opc_o,
   output logic                                   cmd_inc_o,
   output logic [dma_ctrl_pkg::TCDM_ADD_WIDTH-1:0] tcdm_add_o,
   output logic [dma_ctrl_pkg::EXT_ADD_WIDTH-1:0] ext_add_o,
   output logic                                   busy_o
);

   logic                                  alloc_req;
   logic                                  alloc_take;
   logic                                  alloc_gnt;
   logic [dma_ctrl_pkg::SID_WIDTH-1:0]    alloc_ret;
   logic [dma_ctrl_pkg::NB_TRANSFERS-1:0] alloc_clr;
   logic [dma_ctrl_pkg::NB_TRANSFERS-1:0] alloc_status;
   logic                                  alloc_any;
   logic                                  queue_busy;

   ctrl_if ctrl_if_i (
      .*,
      .trans_alloc_req_o    (alloc_req),
      .trans_alloc_take_o   (alloc_take),
      .trans_alloc_gnt_i    (alloc_gnt),
      .trans_alloc_ret_i    (alloc_ret),
      .trans_alloc_clr_o    (alloc_clr),
      .trans_alloc_status_i (alloc_status),
      .queue_busy_o         (queue_busy)
   );

   trans_allocator trans_allocator_i (
      .*,
      .trans_alloc_req_i    (alloc_req),
      .trans_alloc_take_i   (alloc_take),
      .trans_alloc_clr_i    (alloc_clr),
      .trans_alloc_gnt_o    (alloc_gnt),
      .trans_alloc_ret_o    (alloc_ret),
      .trans_alloc_status_o (alloc_status),
      .alloc_any_o          (alloc_any)
   );

   // Busy while a sid is held or a queue still holds data
   assign busy_o = queue_busy | alloc_any;

endmodule

// ==== bench/tb_clock_gen.sv ====
// Bench clock and reset source
// Period of 10 time units, reset held high for the first 16 cycles

module tb_clock_gen (
   output logic clk_o,
   output logic reset_o
);

   initial begin
      clk_o   = 1'b0;
      reset_o = 1'b1;
      repeat (16) @(posedge clk_o);
      #1 reset_o = 1'b0;
   end

   always #5 clk_o = ~clk_o;

endmodule

// ==== bench/tb_dma_ctrl.sv ====
// Testbench for the DMA command front end
// Random register programming against a model of sids and command queues

module tb_dma_ctrl;

   // Five tests of at most 400 cycles each, with a margin of two
   localparam int NUM_TESTS   = 5;
   localparam int TEST_CYCLES = 400;
   localparam int MAX_CYCLES  = NUM_TESTS * TEST_CYCLES * 2;
   localparam int HOLD_LIMIT  = 60;

   logic        clk_i, reset_i;
   logic        req, wr, gnt, r_valid, r_opc, id, r_id;
   logic [31:0] add, wdata, r_data;
   logic        done_p, cmd_req, cmd_gnt, cmd_inc, busy;
   logic [1:0]  done_sid, cmd_sid;
   logic [15:0] cmd_len;
   logic [11:0] tcdm_add;
   logic [28:0] ext_add;
   dma_ctrl_pkg::dma_opc_e cmd_opc;

   // Model state
   logic [3:0]  alloc_m, done_m;
   logic [1:0]  cur_sid_m;
   logic [19:0] cmd_q[$];
   logic [11:0] tcdm_q[$];
   logic [28:0] ext_q[$];
   logic [31:0] seed = 32'd7317;
   logic [15:0] gnt_rnd;
   logic        gnt_en, gnt_seen;
   int          err_count, fail_tests, test_errs, cycles;

   tb_clock_gen i_clk (.clk_o(clk_i), .reset_o(reset_i));

   dma_ctrl_top i_dut (
      .clk_i(clk_i), .reset_i(reset_i),
      .ctrl_targ_req_i(req), .ctrl_targ_type_i(wr), .ctrl_targ_add_i(add),
      .ctrl_targ_data_i(wdata), .ctrl_targ_id_i(id), .ctrl_targ_gnt_o(gnt),
      .ctrl_targ_r_valid_o(r_valid), .ctrl_targ_r_data_o(r_data),
      .ctrl_targ_r_opc_o(r_opc), .ctrl_targ_r_id_o(r_id),
      .trans_done_i(done_p), .trans_done_sid_i(done_sid),
      .cmd_req_o(cmd_req), .cmd_gnt_i(cmd_gnt), .cmd_sid_o(cmd_sid),
      .cmd_len_o(cmd_len), .cmd_opc_o(cmd_opc), .cmd_inc_o(cmd_inc),
      .tcdm_add_o(tcdm_add), .ext_add_o(ext_add), .busy_o(busy)
   );

   function automatic logic [15:0] lcg_step();
      seed = seed * 32'd1103515245 + 32'd12345;
      return seed[31:16];
   endfunction

   function automatic logic [31:0] rand32();
      logic [15:0] hi;
      hi = lcg_step();
      return {hi, lcg_step()};
   endfunction

   function automatic logic [1:0] lowest_free(logic [3:0] held);
      for (int i = 0; i < 4; i++) begin
         if (!held[i]) return 2'(i);
      end
      return 2'd0;
   endfunction

   task automatic check(input logic [31:0] act, input logic [31:0] exp, input string msg);
      if (act !== exp) begin
         $display("ERR @%0t: %s got %h expected %h", $time, msg, act, exp);
         err_count++;
         test_errs++;
      end
   endtask

   task automatic report_failure(input string msg);
      $display("%s at time %0t", msg, $time);
      err_count++;
      test_errs++;
   endtask

   // One bus access with handshake, model update and response check
   task automatic bus_access(input logic w, input logic [2:0] off, input logic [31:0] d);
      logic [31:0] exp_data;
      logic        exp_opc;
      logic        exp_id;
      logic        granted;
      logic [15:0] rnd;
      int          n;
      exp_data = '0;
      exp_opc  = (off > 3'd3);
      @(posedge clk_i);
      #1;
      req   = 1'b1;
      wr    = w;
      add   = {rand32() & 32'h07ff_ffff} << 5 | {27'd0, off, 2'b00};
      wdata = d;
      rnd   = lcg_step();
      id    = rnd[0];
      exp_id = id;
      n = 0;
      @(negedge clk_i);
      while (!gnt && n < HOLD_LIMIT) begin
         n++;
         @(negedge clk_i);
      end
      granted = gnt;
      if (!granted) begin
         report_failure($sformatf("Access to offset %0d was held off and never granted", off));
      end else begin
         case ({w, off})
            4'b0_000: begin
               exp_data  = 32'(lowest_free(alloc_m));
               cur_sid_m = lowest_free(alloc_m);
               alloc_m[cur_sid_m] = 1'b1;
            end
            4'b1_000: cmd_q.push_back({cur_sid_m, d[18], d[17], d[15:0]});
            4'b1_001: tcdm_q.push_back(d[11:0]);
            4'b1_010: ext_q.push_back(d[28:0]);
            4'b0_011: exp_data = 32'(alloc_m & ~done_m);
            4'b1_011: begin
               alloc_m = alloc_m & ~d[3:0];
               done_m  = done_m & ~d[3:0];
            end
            default: ;
         endcase
      end
      @(posedge clk_i);
      #1 req = 1'b0;
      @(negedge clk_i);
      if (granted) begin
         if (!r_valid) begin
            report_failure("No response arrived one cycle after a grant");
         end else begin
            check(r_data, exp_data, "response data");
            check(r_opc, exp_opc, "response r_opc");
            check(r_id, exp_id, "response id");
         end
      end
   endtask

   // Request that must stay ungranted for a number of cycles
   task automatic hold_check(input logic w, input logic [2:0] off, input int n);
      @(posedge clk_i);
      #1;
      req   = 1'b1;
      wr    = w;
      add   = {27'd0, off, 2'b00};
      wdata = rand32();
      repeat (n) begin
         @(negedge clk_i);
         check(gnt, 1'b0, "grant while held off");
      end
      @(posedge clk_i);
      #1 req = 1'b0;
   endtask

   task automatic pulse_done(input logic [1:0] sid);
      @(posedge clk_i);
      #1;
      done_p   = 1'b1;
      done_sid = sid;
      @(posedge clk_i);
      #1 done_p = 1'b0;
      done_m[sid] = 1'b1;
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      gnt_en = 1'b1;
      while ((cmd_q.size() != 0 || cmd_req) && n < 300) begin
         n++;
         @(negedge clk_i);
      end
      if (cmd_q.size() != 0 || tcdm_q.size() != 0 || ext_q.size() != 0) begin
         report_failure("Command queues did not drain");
      end
   endtask

   task automatic end_test(input string name);
      $display("Test %s finished with %0d errors", name, test_errs);
      if (test_errs != 0) fail_tests++;
      test_errs = 0;
   endtask

   // Response follows every grant, and no response without one
   always @(negedge clk_i) begin
      if (!reset_i) check(r_valid, gnt_seen, "response valid vs previous grant");
      gnt_seen = gnt && !reset_i;
   end

   //************************************************************
   // Downstream command monitor and random grant
   //************************************************************

   always @(negedge clk_i) begin
      if (cmd_req) begin
         if (cmd_q.size() == 0 || tcdm_q.size() == 0 || ext_q.size() == 0) begin
            report_failure("Command offered while a queue was empty in the model");
         end else if (cmd_gnt) begin
            check({cmd_sid, cmd_inc, cmd_opc, cmd_len}, cmd_q.pop_front(), "command entry");
            check(tcdm_add, tcdm_q.pop_front(), "tcdm address");
            check(ext_add, ext_q.pop_front(), "ext address");
         end
      end
   end

   always @(posedge clk_i) begin
      #1;
      gnt_rnd = lcg_step();
      cmd_gnt = gnt_en && gnt_rnd[3];
   end

   always @(posedge clk_i) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout after %0d cycles, the run did not finish", cycles);
         $display("Test failed");
         $finish;
      end
   end

   initial begin
      logic [31:0] d;
      req       = 0;
      wr        = 0;
      add       = '0;
      wdata     = '0;
      id        = 0;
      done_p    = 0;
      done_sid  = '0;
      cmd_gnt   = 0;
      gnt_en    = 0;
      gnt_seen  = 0;
      alloc_m   = '0;
      done_m    = '0;
      cur_sid_m = '0;
      err_count  = 0;
      fail_tests = 0;
      test_errs  = 0;
      cycles     = 0;
      @(negedge reset_i);
      @(negedge clk_i);
      check(busy, 1'b0, "busy after reset");
      check(cmd_req, 1'b0, "cmd_req after reset");

      // Sid allocation and hold-off on a full allocator
      repeat (4) bus_access(1'b0, 3'd0, '0);
      check(busy, 1'b1, "busy with sids held");
      hold_check(1'b0, 3'd0, 8);
      bus_access(1'b1, 3'd3, 32'h4);
      bus_access(1'b0, 3'd0, '0);
      bus_access(1'b1, 3'd3, 32'hf);
      end_test("sid_alloc");

      // Programming order with random downstream grants
      gnt_en = 1'b1;
      repeat (12) begin
         bus_access(1'b0, 3'd0, '0);
         bus_access(1'b1, 3'd0, rand32());
         bus_access(1'b1, 3'd1, rand32());
         bus_access(1'b1, 3'd2, rand32());
         d = rand32();
         if (d[2]) pulse_done(cur_sid_m);
         bus_access(1'b0, 3'd3, '0);
         bus_access(1'b1, 3'd3, 32'(1) << cur_sid_m);
      end
      wait_drained();
      end_test("cmd_order");

      // Back-pressure on the TCDM address queue
      gnt_en = 1'b0;
      @(posedge clk_i);
      #1 cmd_gnt = 1'b0;
      bus_access(1'b0, 3'd0, '0);
      bus_access(1'b1, 3'd0, rand32());
      bus_access(1'b1, 3'd2, rand32());
      bus_access(1'b1, 3'd1, rand32());
      bus_access(1'b1, 3'd1, rand32());
      hold_check(1'b1, 3'd1, 6);
      gnt_en = 1'b1;
      bus_access(1'b1, 3'd1, rand32());
      bus_access(1'b1, 3'd0, rand32());
      bus_access(1'b1, 3'd2, rand32());
      bus_access(1'b1, 3'd0, rand32());
      bus_access(1'b1, 3'd2, rand32());
      wait_drained();
      bus_access(1'b1, 3'd3, 32'hf);
      end_test("back_pressure");

      // Status bitmap through done pulses and clears
      repeat (10) begin
         while (alloc_m != 4'hf) bus_access(1'b0, 3'd0, '0);
         d = rand32();
         if (alloc_m[d[1:0]] && !done_m[d[1:0]]) pulse_done(d[1:0]);
         bus_access(1'b0, 3'd3, '0);
         bus_access(1'b1, 3'd3, {28'd0, d[7:4]});
         bus_access(1'b0, 3'd3, '0);
      end
      bus_access(1'b1, 3'd3, 32'hf);
      end_test("status");

      // Unmapped offsets and final idle state
      repeat (8) begin
         d = rand32();
         bus_access(d[0], 3'd4 + 3'(d[2:1]), rand32());
      end
      @(negedge clk_i);
      check(busy, 1'b0, "busy after clear and drain");
      end_test("unmapped_busy");

      $display("Tests run %0d, tests failed %0d, errors %0d", NUM_TESTS, fail_tests,
               err_count);
      if (err_count == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== flist.f ====
design/dma_ctrl_pkg.sv
design/cmd_fifo.sv
design/ctrl_fsm.sv
design/trans_allocator.sv
design/ctrl_if.sv
design/dma_ctrl_top.sv
bench/tb_clock_gen.sv
bench/tb_dma_ctrl.sv
